/* mc_pkg.sv */
`default_nettype none

package mc_pkg;

	// Bus and datapath widths.
	localparam int SAMPLE_W = 32;
	localparam int SUM_W = 48;
	localparam int SEQ_W = 16;

	// Upper bound on the core array size.
	localparam int MAX_CORES = 64;
	localparam int CORE_ID_W = $clog2(MAX_CORES);

	// One input sample.
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Block sum, no overflow up to 65536 samples.
	typedef logic signed [SUM_W-1:0] sum_t;

	typedef logic [CORE_ID_W-1:0] core_id_t;

	// Block number, wraps.
	typedef logic [SEQ_W-1:0] seq_t;

	// Core FSM.
	typedef enum logic {
		CORE_LOAD,
		CORE_EMIT
	} core_state_t;

	// Reset sequencer FSM.
	typedef enum logic {
		SEQ_WAIT,
		SEQ_DONE
	} seq_state_t;

endpackage

`default_nettype wire

/* core_reset_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module core_reset_sequencer #(
	parameter int NUM_CORES = 8,
	parameter int START_GAP = 16
) (
	input  wire                  clk,
	input  wire                  rst,
	output logic [NUM_CORES-1:0] core_rst
);

	localparam int CNT_W = $clog2(START_GAP + 1);
	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

	mc_pkg::seq_state_t state;
	logic [CNT_W-1:0] gap_cnt;
	logic [IDX_W-1:0] next_core;
	logic [NUM_CORES-1:0] released;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mc_pkg::SEQ_WAIT;
			gap_cnt <= '0;
			next_core <= '0;
			core_rst <= '1; // Whole array held.
		end else begin
			case (state)
				mc_pkg::SEQ_WAIT: begin
					if (gap_cnt == CNT_W'(START_GAP)) begin
						core_rst[next_core] <= 1'b0;
						gap_cnt <= CNT_W'(1); // Release edge opens the next gap.
						next_core <= next_core + 1'b1;
						if (next_core == IDX_W'(NUM_CORES - 1)) begin
							state <= mc_pkg::SEQ_DONE;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				mc_pkg::SEQ_DONE: begin
					gap_cnt <= '0; // Idle until next reset.
				end
				default: begin
					state <= mc_pkg::SEQ_WAIT;
				end
			endcase
		end
	end

	assign released = ~core_rst;

	// Released cores form a run from core 0 upward and never re-enter reset.
	a_release_order: assert property (@(posedge clk) disable iff (rst)
		((released & (released + 1'b1)) == '0) &&
		((core_rst & ~$past(core_rst)) == '0));

endmodule

`default_nettype wire

/* block_accum_core.sv */
`timescale 1ns/1ps
`default_nettype none

module block_accum_core #(
	parameter int BLOCK_LEN = 4
) (
	input  wire                  clk,
	input  wire                  rst,
	output logic                 load_req,
	input  wire                  load_grant,
	input  wire                  load_take,
	input  wire mc_pkg::sample_t load_data,
	input  wire mc_pkg::seq_t    load_seq,
	output logic                 res_valid,
	output mc_pkg::sum_t         res_sum,
	output mc_pkg::seq_t         res_seq,
	input  wire                  res_taken
);

	localparam int CNT_W = (BLOCK_LEN > 1) ? $clog2(BLOCK_LEN) : 1;

	mc_pkg::core_state_t state;
	logic [CNT_W-1:0] cnt;
	mc_pkg::sum_t acc;
	mc_pkg::seq_t blk_seq;
	mc_pkg::sum_t next_sum;
	logic accept;
	logic first;
	logic last;

	// Requesting only while loading and released.
	assign load_req = (state == mc_pkg::CORE_LOAD) && !rst;
	assign res_valid = (state == mc_pkg::CORE_EMIT);

	assign accept = load_req && load_grant && load_take;
	assign first = (cnt == '0);
	assign last = (cnt == CNT_W'(BLOCK_LEN - 1));

	// Fresh sum on the first sample of a block.
	assign next_sum = (first ? mc_pkg::sum_t'(0) : acc) + mc_pkg::sum_t'(load_data);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mc_pkg::CORE_LOAD;
			cnt <= '0;
		end else begin
			case (state)
				mc_pkg::CORE_LOAD: begin
					if (accept) begin
						if (last) begin
							cnt <= '0;
							state <= mc_pkg::CORE_EMIT;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				mc_pkg::CORE_EMIT: begin
					if (res_taken) begin
						state <= mc_pkg::CORE_LOAD;
					end
				end
				default: begin
					state <= mc_pkg::CORE_LOAD;
				end
			endcase
		end
	end

	// Accumulator and published result.
	always_ff @(posedge clk) begin
		if (accept) begin
			acc <= next_sum;
			if (first) begin
				blk_seq <= load_seq; // Tag follows the block's first sample.
			end
			if (last) begin
				res_sum <= next_sum;
				res_seq <= first ? load_seq : blk_seq;
			end
		end
	end

	// A pending result must not change before the selector takes it.
	a_result_hold: assert property (@(posedge clk) disable iff (rst)
		res_valid && !res_taken |=> res_valid && $stable(res_sum) && $stable(res_seq));

endmodule

`default_nettype wire

/* input_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module input_dispatch #(
	parameter int NUM_CORES = 8,
	parameter int BLOCK_LEN = 4
) (
	input  wire                  clk,
	input  wire                  rst,
	input  wire mc_pkg::sample_t in_data,
	input  wire                  in_valid,
	output logic                 in_ready,
	input  wire [NUM_CORES-1:0]  load_req,
	output logic [NUM_CORES-1:0] load_grant,
	output logic                 load_take,
	output mc_pkg::sample_t      load_data,
	output mc_pkg::seq_t         load_seq
);

	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
	localparam int CNT_W = (BLOCK_LEN > 1) ? $clog2(BLOCK_LEN) : 1;

	logic locked;
	logic [IDX_W-1:0] lock_idx;
	logic [IDX_W-1:0] pick_idx;
	logic [IDX_W-1:0] grant_idx;
	logic [CNT_W-1:0] cnt;
	mc_pkg::seq_t seq_cnt;

	// Lowest requesting core wins.
	always_comb begin
		pick_idx = '0;
		for (int i = NUM_CORES - 1; i >= 0; i--) begin
			if (load_req[i]) begin
				pick_idx = IDX_W'(i);
			end
		end
	end

	assign grant_idx = locked ? lock_idx : pick_idx;

	always_comb begin
		load_grant = '0;
		if (locked || (|load_req)) begin
			load_grant[grant_idx] = 1'b1;
		end
	end

	assign in_ready = |(load_grant & load_req);
	assign load_take = in_valid && in_ready;
	assign load_data = in_data;
	assign load_seq = seq_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			locked <= 1'b0;
			lock_idx <= '0;
			cnt <= '0;
			seq_cnt <= '0;
		end else if (load_take) begin
			if (cnt == CNT_W'(BLOCK_LEN - 1)) begin
				locked <= 1'b0; // Block complete.
				cnt <= '0;
				seq_cnt <= seq_cnt + 1'b1;
			end else begin
				locked <= 1'b1;
				lock_idx <= grant_idx;
				cnt <= cnt + 1'b1;
			end
		end
	end

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(load_grant));

	// The locked core stays in its load phase until the block ends.
	a_lock_held: assert property (@(posedge clk) disable iff (rst)
		locked |-> load_req[lock_idx]);

endmodule

`default_nettype wire

/* result_select.sv */
`timescale 1ns/1ps
`default_nettype none

module result_select #(
	parameter int NUM_CORES = 8
) (
	input  wire                                clk,
	input  wire                                rst,
	input  wire [NUM_CORES-1:0]                res_valid,
	input  wire mc_pkg::sum_t [NUM_CORES-1:0]  res_sum,
	input  wire mc_pkg::seq_t [NUM_CORES-1:0]  res_seq,
	output logic [NUM_CORES-1:0]               res_taken,
	output mc_pkg::sum_t                       out_sum,
	output mc_pkg::core_id_t                   out_core,
	output mc_pkg::seq_t                       out_seq,
	output logic                               out_valid,
	input  wire                                out_ready
);

	localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

	logic held;
	logic [IDX_W-1:0] held_idx;
	logic [IDX_W-1:0] scan_idx;
	logic [IDX_W-1:0] sel_idx;

	// Fixed priority, core 0 first.
	always_comb begin
		scan_idx = '0;
		for (int i = NUM_CORES - 1; i >= 0; i--) begin
			if (res_valid[i]) begin
				scan_idx = IDX_W'(i);
			end
		end
	end

	// A stalled result keeps the bus even if a lower core becomes ready.
	assign sel_idx = held ? held_idx : scan_idx;

	assign out_valid = |res_valid;
	assign out_sum = res_sum[sel_idx];
	assign out_seq = res_seq[sel_idx];
	assign out_core = mc_pkg::core_id_t'(sel_idx);

	always_comb begin
		res_taken = '0;
		if (out_valid && out_ready) begin
			res_taken[sel_idx] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
		end else begin
			held <= out_valid && !out_ready;
		end
	end

	always_ff @(posedge clk) begin
		held_idx <= sel_idx;
	end

	// Only a core with a pending result can be taken.
	a_taken_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(res_taken) && ((res_taken & ~res_valid) == '0));

	// Output bus holds under back-pressure.
	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=>
		out_valid && $stable(out_sum) && $stable(out_core) && $stable(out_seq));

endmodule

`default_nettype wire

/* multicore.sv */
`timescale 1ns/1ps
`default_nettype none

module multicore #(
	parameter int NUM_CORES = 8,
	parameter int BLOCK_LEN = 4,
	parameter int START_GAP = 16
) (
	input  wire                  clk,
	input  wire                  rst,
	input  wire mc_pkg::sample_t in_data,
	input  wire                  in_valid,
	output logic                 in_ready,
	output mc_pkg::sum_t         out_sum,
	output mc_pkg::core_id_t     out_core,
	output mc_pkg::seq_t         out_seq,
	output logic                 out_valid,
	input  wire                  out_ready
);

	logic [NUM_CORES-1:0] core_rst;
	logic [NUM_CORES-1:0] load_grant;
	logic [NUM_CORES-1:0] res_taken;
	logic load_take;
	mc_pkg::sample_t load_data;
	mc_pkg::seq_t load_seq;

	// Driven bit by bit from the core array.
	wire [NUM_CORES-1:0] load_req;
	wire [NUM_CORES-1:0] res_valid;
	wire mc_pkg::sum_t [NUM_CORES-1:0] res_sum;
	wire mc_pkg::seq_t [NUM_CORES-1:0] res_seq;

	if (NUM_CORES < 1 || NUM_CORES > mc_pkg::MAX_CORES) begin : g_bad_count
		$error("NUM_CORES must be between 1 and %0d", mc_pkg::MAX_CORES);
	end

	core_reset_sequencer #(
		.NUM_CORES(NUM_CORES),
		.START_GAP(START_GAP)
	) u_seq (
		.clk(clk),
		.rst(rst),
		.core_rst(core_rst)
	);

	input_dispatch #(
		.NUM_CORES(NUM_CORES),
		.BLOCK_LEN(BLOCK_LEN)
	) u_dispatch (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.load_req(load_req),
		.load_grant(load_grant),
		.load_take(load_take),
		.load_data(load_data),
		.load_seq(load_seq)
	);

	for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
		block_accum_core #(
			.BLOCK_LEN(BLOCK_LEN)
		) u_core (
			.clk(clk),
			.rst(core_rst[i]), // Staggered release.
			.load_req(load_req[i]),
			.load_grant(load_grant[i]),
			.load_take(load_take),
			.load_data(load_data),
			.load_seq(load_seq),
			.res_valid(res_valid[i]),
			.res_sum(res_sum[i]),
			.res_seq(res_seq[i]),
			.res_taken(res_taken[i])
		);
	end

	result_select #(
		.NUM_CORES(NUM_CORES)
	) u_select (
		.clk(clk),
		.rst(rst),
		.res_valid(res_valid),
		.res_sum(res_sum),
		.res_seq(res_seq),
		.res_taken(res_taken),
		.out_sum(out_sum),
		.out_core(out_core),
		.out_seq(out_seq),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst
);

	// 20 ns period.
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst = 1'b0; // Same offset as the other inputs.
	end

endmodule

`default_nettype wire

/* multicore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module multicore_tb;

	localparam int NUM_CORES = 8;
	localparam int BLOCK_LEN = 4;
	localparam int START_GAP = 16;
	localparam int NUM_BLOCKS = 400;
	localparam int TOTAL_SAMPLES = NUM_BLOCKS * BLOCK_LEN;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * BLOCK_LEN * 10 + NUM_CORES * START_GAP;
	localparam int READY_CYC = START_GAP + 2; // First edge that samples in_ready high.
	localparam int STALL_START = 1000;
	localparam int STALL_END = 1300;
	localparam int SEED = 32'h9504_9148;

	wire clk;
	wire rst;
	mc_pkg::sample_t in_data;
	logic in_valid;
	wire in_ready;
	mc_pkg::sum_t out_sum;
	mc_pkg::core_id_t out_core;
	mc_pkg::seq_t out_seq;
	wire out_valid;
	logic out_ready;

	mc_pkg::sample_t samples[$]; // Every accepted input sample, in order.
	bit seen[NUM_BLOCKS];
	int cyc = 0;
	int rst_cycles = 0;
	int received = 0;
	int sent = 0;
	int missing;
	logic took;
	mc_pkg::sum_t in_total = '0;
	mc_pkg::sum_t out_total = '0;
	logic prev_stall = 1'b0;
	mc_pkg::sum_t prev_sum;
	mc_pkg::core_id_t prev_core;
	mc_pkg::seq_t prev_seq;

	tb_clock #(.RESET_CYCLES(16)) u_clock (.clk(clk), .rst(rst));

	multicore #(
		.NUM_CORES(NUM_CORES),
		.BLOCK_LEN(BLOCK_LEN),
		.START_GAP(START_GAP)
	) DUT (
		.clk(clk),
		.rst(rst),
		.in_data(in_data),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_sum(out_sum),
		.out_core(out_core),
		.out_seq(out_seq),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		abort_run();
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_sum(input string name, input mc_pkg::sum_t got, input mc_pkg::sum_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_seq(input string name, input mc_pkg::seq_t got, input mc_pkg::seq_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_core(input string name, input mc_pkg::core_id_t got,
			input mc_pkg::core_id_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Sum of block n, taken from the accepted input stream.
	function automatic mc_pkg::sum_t block_sum(input int n);
		mc_pkg::sum_t s;
		s = '0;
		for (int j = 0; j < BLOCK_LEN; j++) begin
			s += mc_pkg::sum_t'(samples[n * BLOCK_LEN + j]);
		end
		return s;
	endfunction

	task automatic record_output();
		int n;
		n = int'(out_seq);
		if (n >= samples.size() / BLOCK_LEN) begin
			stop_with_failure($sformatf("output sequence number %0d was never sent", n));
		end else if (seen[n]) begin
			stop_with_failure($sformatf("sequence number %0d came out twice", n));
		end else begin
			seen[n] = 1'b1;
			received++;
			out_total += out_sum;
			check_sum("out_sum", out_sum, block_sum(n));
		end
	endtask

	// Samples at the edge, before the DUT's registers update.
	always @(posedge clk) begin
		if (rst) begin
			rst_cycles++;
			if (rst_cycles >= 2) begin
				check_flag("out_valid", out_valid, 1'b0);
				check_flag("in_ready", in_ready, 1'b0);
			end
		end else begin
			cyc++;
			if (cyc >= TIMEOUT_CYCLES) begin
				stop_with_failure($sformatf("timeout after %0d cycles", cyc));
			end
			if (cyc < READY_CYC) begin
				check_flag("in_ready", in_ready, 1'b0);
			end else if (cyc == READY_CYC) begin
				check_flag("in_ready", in_ready, 1'b1);
			end
			if (cyc == STALL_END) begin
				check_flag("in_ready", in_ready, 1'b0); // Array full.
			end
			if (in_valid && in_ready) begin
				samples.push_back(in_data);
				in_total += mc_pkg::sum_t'(in_data);
			end
			if (prev_stall) begin
				check_flag("out_valid", out_valid, 1'b1);
				check_sum("out_sum", out_sum, prev_sum);
				check_core("out_core", out_core, prev_core);
				check_seq("out_seq", out_seq, prev_seq);
			end
			if (out_valid && int'(out_core) >= NUM_CORES) begin
				stop_with_failure($sformatf("out_core %0d is not a real core", out_core));
			end else if (out_valid && cyc < START_GAP * (int'(out_core) + 1)) begin
				stop_with_failure($sformatf("core %0d gave a result at cycle %0d, before release",
					out_core, cyc));
			end
			if (out_valid && out_ready) begin
				record_output();
			end
			prev_stall = out_valid && !out_ready;
			prev_sum = out_sum;
			prev_core = out_core;
			prev_seq = out_seq;
		end
	end

	// Output back-pressure with one long full stall.
	initial begin
		wait (rst === 1'b1);
		wait (rst === 1'b0);
		forever begin
			@(posedge clk);
			#2;
			if (cyc >= STALL_START && cyc < STALL_END) begin
				out_ready = 1'b0;
			end else begin
				out_ready = ($urandom % 100) < 60;
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		in_data = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		wait (rst === 1'b1);
		wait (rst === 1'b0);
		while (sent < TOTAL_SAMPLES) begin
			@(posedge clk);
			took = in_valid && in_ready;
			#2;
			if (took) begin
				sent++;
			end
			if (!in_valid || took) begin // Hold a pending sample.
				if (sent < TOTAL_SAMPLES) begin
					in_valid = ($urandom % 100) < 70;
					in_data = mc_pkg::sample_t'($urandom);
				end else begin
					in_valid = 1'b0;
				end
			end
		end
		wait (received == NUM_BLOCKS);
		repeat (2) @(posedge clk);
		missing = 0;
		foreach (seen[n]) begin
			if (!seen[n]) begin
				missing++;
			end
		end
		check_sum("total sum", out_total, in_total);
		if (missing == 0 && samples.size() == TOTAL_SAMPLES && cyc > STALL_END) begin
			$display("Test passed");
			$finish;
		end else begin
			stop_with_failure($sformatf("%0d blocks missing, %0d samples accepted, %0d cycles",
				missing, samples.size(), cyc));
		end
	end

endmodule

`default_nettype wire

/* multicore.f */
mc_pkg.sv
core_reset_sequencer.sv
block_accum_core.sv
input_dispatch.sv
result_select.sv
multicore.sv
tb_clock.sv
multicore_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it.
# The exit status is the simulator's; a failing run ends in $fatal.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	-f multicore.f --top-module multicore_tb -o multicore_sim &&
./obj_dir/multicore_sim || exit 1
